// ==== camera_settings.svh ====
`ifndef CAMERA_SETTINGS_SVH
`define CAMERA_SETTINGS_SVH

// ==================================================
// Sensor sample format
// ==================================================
`define CCD_PIXEL_WIDTH   12   // Bits per raw and colour sample
`define CCD_MAX_LINE      640  // Line buffer depth in pixels

// ==================================================
// Counters and display
// ==================================================
`define CCD_COUNT_WIDTH   16   // Column and line counters
`define FRAME_COUNT_WIDTH 24   // Captured frames
`define HEX_DIGITS        6    // Seven-segment digits on the board

// One nibble per digit
// FRAME_COUNT_WIDTH is 4 * HEX_DIGITS

`endif

// ==== camera_pkg.sv ====
`include "camera_settings.svh"

package camera_pkg;

  // One raw or colour sample
  typedef logic [`CCD_PIXEL_WIDTH-1:0] pixel_t;

  // Column or line position
  typedef logic [`CCD_COUNT_WIDTH-1:0] count_t;

  // Sensor bus as seen on the pins
  typedef struct packed {
    logic   fval;    // Frame valid level
    logic   lval;    // Line valid level
    pixel_t data;
  } ccd_raw_t;

  // Pixel after capture gating
  typedef struct packed {
    logic   valid;   // One strobe per captured sample
    pixel_t data;
    count_t column;  // From 0 within the line
    count_t line;    // From 0 within the frame
  } ccd_pixel_t;

  // Two memory-port words per pixel
  typedef struct packed {
    logic        valid;
    logic [15:0] word_a;  // 0, G[11:7], B[11:2]
    logic [15:0] word_b;  // 0, G[6:2], R[11:2]
  } pixel_words_t;

  // Digit 0 holds the low nibble and bit 0 drives segment a (low lights)
  typedef logic [`HEX_DIGITS-1:0][6:0] hex_segments_t;

  // Packing into the two 16-bit words
  function automatic pixel_words_t pack_pixel(input logic valid, input pixel_t red,
                                              input pixel_t green, input pixel_t blue);
    pixel_words_t w;
    w.valid  = valid;
    w.word_a = {1'b0, green[11:7], blue[11:2]};
    w.word_b = {1'b0, green[6:2], red[11:2]};
    return w;
  endfunction

endpackage

// ==== ccd_capture.sv ====
`include "camera_settings.svh"

module ccd_capture (
  input  logic                          CLOCK_50,
  input  logic                          rst,
  input  camera_pkg::ccd_raw_t          raw,
  input  logic                          capture_start,
  input  logic                          capture_stop,
  output camera_pkg::ccd_pixel_t        captured,
  output logic [`FRAME_COUNT_WIDTH-1:0] frame_count
);

  // ==================================================
  // Input register and edge detect
  // ==================================================
  camera_pkg::ccd_raw_t raw_q;  // Sensor bus in the first stage
  logic fval_d;                 // fval one sample back
  logic lval_d;
  logic fval_rise;
  logic fval_fall;
  logic lval_fall;

  always_ff @(posedge CLOCK_50)
  begin
    raw_q.data <= raw.data;
    if (rst)
    begin
      raw_q.fval <= 1'b0;
      raw_q.lval <= 1'b0;
      fval_d     <= 1'b0;
      lval_d     <= 1'b0;
    end
    else
    begin
      raw_q.fval <= raw.fval;
      raw_q.lval <= raw.lval;
      fval_d     <= raw_q.fval;
      lval_d     <= raw_q.lval;
    end
  end

  assign fval_rise = raw_q.fval & ~fval_d;
  assign fval_fall = ~raw_q.fval & fval_d;
  assign lval_fall = ~raw_q.lval & lval_d;  // End of a line

  // ==================================================
  // Capture gating
  // ==================================================
  logic armed;        // Start seen and no stop since
  logic capturing;    // Inside a captured frame
  logic capture_now;  // Current sample belongs to a captured frame
  logic pixel_valid;
  logic frame_end_q;  // Captured frame just closed

  // Frame start decides on armed and the frame keeps that status afterwards
  assign capture_now = raw_q.fval & (fval_rise ? armed : capturing);
  assign pixel_valid = capture_now & raw_q.lval;

  always_ff @(posedge CLOCK_50)
  begin
    if (rst)
    begin
      armed       <= 1'b0;
      capturing   <= 1'b0;
      frame_end_q <= 1'b0;
    end
    else
    begin
      if (capture_stop)
        armed <= 1'b0;  // Stop wins over start
      else if (capture_start)
        armed <= 1'b1;
      capturing   <= capture_now;
      frame_end_q <= fval_fall & capturing;
    end
  end

  // ==================================================
  // Column, line and frame counters
  // ==================================================
  camera_pkg::count_t col_cnt;   // Valid pixels so far in this line
  camera_pkg::count_t line_cnt;  // Lines so far in this frame

  always_ff @(posedge CLOCK_50)
  begin
    if (rst)
    begin
      col_cnt  <= '0;
      line_cnt <= '0;
    end
    else
    begin
      if (!raw_q.lval)
        col_cnt <= '0;
      else if (pixel_valid)
        col_cnt <= col_cnt + 1'b1;
      if (!raw_q.fval)
        line_cnt <= '0;
      else if (lval_fall)
        line_cnt <= line_cnt + 1'b1;
    end
  end

  // Output stage
  always_ff @(posedge CLOCK_50)
  begin
    captured.data   <= raw_q.data;
    captured.column <= col_cnt;
    captured.line   <= line_cnt;
    if (rst)
    begin
      captured.valid <= 1'b0;
      frame_count    <= '0;
    end
    else
    begin
      captured.valid <= pixel_valid;
      if (frame_end_q)
        frame_count <= frame_count + 1'b1;  // Second edge after fval low
    end
  end

  // Column indexes the line buffer downstream
  assert property (@(posedge CLOCK_50) disable iff (rst)
    captured.valid |-> captured.column < `CCD_MAX_LINE);

endmodule

// ==== line_buffer.sv ====
`include "camera_settings.svh"

module line_buffer (
  input  logic                        CLOCK_50,
  input  logic                        wr_en,
  input  logic [`CCD_COUNT_WIDTH-1:0] column,
  input  camera_pkg::pixel_t          wr_data,
  output camera_pkg::pixel_t          rd_data
);

  localparam int ADDR_WIDTH = $clog2(`CCD_MAX_LINE);

  camera_pkg::pixel_t    mem [`CCD_MAX_LINE];  // One sensor line
  logic [ADDR_WIDTH-1:0] addr;

  assign addr = column[ADDR_WIDTH-1:0];  // Column stays below the depth

  // Read first, then overwrite
  // rd_data holds the same column from the line before
  always_ff @(posedge CLOCK_50)
  begin
    if (wr_en)
    begin
      rd_data   <= mem[addr];
      mem[addr] <= wr_data;
    end
  end

endmodule

// ==== bayer_demosaic.sv ====
`include "camera_settings.svh"

module bayer_demosaic (
  input  logic                     CLOCK_50,
  input  logic                     rst,
  input  camera_pkg::ccd_pixel_t   captured,
  output camera_pkg::pixel_words_t words
);

  // ==================================================
  // 2x2 window
  // ==================================================
  camera_pkg::pixel_t above;         // Same column, previous line
  camera_pkg::pixel_t cur_q;
  camera_pkg::pixel_t left_q;
  camera_pkg::pixel_t above_left_q;
  logic               s2_valid;      // Window complete
  logic               s2_col_odd;
  logic               s2_line_odd;

  line_buffer i_line_buffer (
    .CLOCK_50 (CLOCK_50),
    .wr_en    (captured.valid),
    .column   (captured.column),
    .wr_data  (captured.data),
    .rd_data  (above)
  );

  always_ff @(posedge CLOCK_50)
  begin
    if (captured.valid)
    begin
      cur_q        <= captured.data;
      left_q       <= cur_q;         // Previous pixel in the line
      above_left_q <= above;         // Buffer output of the last sample
    end
    s2_col_odd  <= captured.column[0];
    s2_line_odd <= captured.line[0];
    if (rst)
      s2_valid <= 1'b0;
    else
      s2_valid <= captured.valid && (captured.column != '0) && (captured.line != '0);
  end

  // ==================================================
  // Colour select by parity
  // ==================================================
  // G R on even lines and B G on odd lines
  camera_pkg::pixel_t        red;
  camera_pkg::pixel_t        blue;
  camera_pkg::pixel_t        green_a;
  camera_pkg::pixel_t        green_b;
  camera_pkg::pixel_t        green;
  logic [`CCD_PIXEL_WIDTH:0] green_sum;  // One spare bit for the carry

  always_comb
  begin
    case ({s2_line_odd, s2_col_odd})
      2'b00:  // Current on G of a G R line
      begin
        red     = left_q;
        blue    = above;
        green_a = cur_q;
        green_b = above_left_q;
      end
      2'b01:  // Current on R
      begin
        red     = cur_q;
        blue    = above_left_q;
        green_a = left_q;
        green_b = above;
      end
      2'b10:  // Current on B
      begin
        red     = above_left_q;
        blue    = cur_q;
        green_a = left_q;
        green_b = above;
      end
      default:  // Current on G of a B G line
      begin
        red     = above;
        blue    = left_q;
        green_a = cur_q;
        green_b = above_left_q;
      end
    endcase
  end

  assign green_sum = green_a + green_b;
  assign green     = green_sum[`CCD_PIXEL_WIDTH:1];  // Average of both greens

  // Word register
  always_ff @(posedge CLOCK_50)
  begin
    words <= camera_pkg::pack_pixel(s2_valid, red, green, blue);
    if (rst)
      words.valid <= 1'b0;
  end

  // A line start never has a window behind it
  assert property (@(posedge CLOCK_50) disable iff (rst)
    (captured.valid && captured.column == '0) |=> ##1 !words.valid);

endmodule

// ==== frame_count_display.sv ====
`include "camera_settings.svh"

module frame_count_display (
  input  logic [`FRAME_COUNT_WIDTH-1:0] frame_count,
  output camera_pkg::hex_segments_t     hex
);

  // ==================================================
  // Segment table
  // ==================================================
  // Bit order g f e d c b a with a segment lit when low
  function automatic logic [6:0] seg7(input logic [3:0] nibble);
    logic [6:0] seg;
    case (nibble)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b0000011;  // Lower case b
      4'hc:    seg = 7'b1000110;
      4'hd:    seg = 7'b0100001;  // Lower case d
      4'he:    seg = 7'b0000110;
      default: seg = 7'b0001110;  // F
    endcase
    return seg;
  endfunction

  // One nibble per digit with digit 0 lowest
  always_comb
  begin
    for (int i = 0; i < `HEX_DIGITS; i++)
    begin
      hex[i] = seg7(frame_count[4*i +: 4]);
    end
  end

endmodule

// ==== camera_pipeline.sv ====
`include "camera_settings.svh"

module camera_pipeline (
  input  logic                     CLOCK_50,
  input  logic                     rst,
  input  camera_pkg::ccd_raw_t     raw,
  input  logic                     capture_start,
  input  logic                     capture_stop,
  output camera_pkg::pixel_words_t words,
  output camera_pkg::hex_segments_t hex
);

  // ==================================================
  // Capture to demosaic and display
  // ==================================================
  camera_pkg::ccd_pixel_t        captured;     // Gated pixel stream
  logic [`FRAME_COUNT_WIDTH-1:0] frame_count;

  ccd_capture i_ccd_capture (
    .CLOCK_50      (CLOCK_50),
    .rst           (rst),
    .raw           (raw),
    .capture_start (capture_start),
    .capture_stop  (capture_stop),
    .captured      (captured),
    .frame_count   (frame_count)
  );

  // Pixel path in two stages
  bayer_demosaic i_bayer_demosaic (
    .CLOCK_50 (CLOCK_50),
    .rst      (rst),
    .captured (captured),
    .words    (words)
  );

  // Frame count on the digits
  frame_count_display i_frame_count_display (
    .frame_count (frame_count),
    .hex         (hex)
  );

endmodule

// ==== camera_pipeline_tb.sv ====
`include "camera_settings.svh"

module camera_pipeline_tb;

  logic                      CLOCK_50;
  logic                      rst;
  camera_pkg::ccd_raw_t      raw;
  logic                      capture_start;
  logic                      capture_stop;
  camera_pkg::pixel_words_t  words;
  camera_pkg::hex_segments_t hex;

  logic [31:0] word_q [$];  // {word_a, word_b} per valid output
  logic [15:0] lfsr_state;  // Blanking length source
  int          frame_no;    // Frames sent so far for error lines

  camera_pipeline i_dut (
    .CLOCK_50      (CLOCK_50),
    .rst           (rst),
    .raw           (raw),
    .capture_start (capture_start),
    .capture_stop  (capture_stop),
    .words         (words),
    .hex           (hex)
  );

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #2 CLOCK_50 = ~CLOCK_50;
  end

  // Output monitor samples half a cycle after the edge
  always @(negedge CLOCK_50)
  begin
    if (words.valid === 1'b1)
      word_q.push_back({words.word_a, words.word_b});
  end

  // ==================================================
  // Checks and failure
  // ==================================================
  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Run aborted");
  endtask

  // Segment a in bit 0 and lit when low
  function automatic logic [6:0] segment_code(input logic [3:0] nibble);
    logic [6:0] code;
    case (nibble)
      4'h0:    code = 7'b1000000;
      4'h1:    code = 7'b1111001;
      4'h2:    code = 7'b0100100;
      4'h3:    code = 7'b0110000;
      4'h4:    code = 7'b0011001;
      4'h5:    code = 7'b0010010;
      4'h6:    code = 7'b0000010;
      4'h7:    code = 7'b1111000;
      4'h8:    code = 7'b0000000;
      4'h9:    code = 7'b0010000;
      4'ha:    code = 7'b0001000;
      4'hb:    code = 7'b0000011;
      4'hc:    code = 7'b1000110;
      4'hd:    code = 7'b0100001;
      4'he:    code = 7'b0000110;
      default: code = 7'b0001110;
    endcase
    return code;
  endfunction

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic next_cycle();
    @(posedge CLOCK_50);
    #1;  // Inputs change just after the edge
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) next_cycle();
    rst = 1'b0;
  endtask

  // Blanking of 2 to 5 cycles
  task automatic blank(input logic fval_level);
    int n;
    n = 2;
    for (int b = 0; b < 2; b++)
    begin
      n = n + (int'(lfsr_state[0]) << b);  // One step per bit taken
      lfsr_state = lfsr_next(lfsr_state);
    end
    raw.fval = fval_level;
    raw.lval = 1'b0;
    repeat (n) next_cycle();
  endtask

  task automatic send_line(input camera_pkg::pixel_t p0, p1, p2, p3);
    camera_pkg::pixel_t px [4];
    px = '{p0, p1, p2, p3};
    for (int i = 0; i < 4; i++)
    begin
      raw.fval = 1'b1;
      raw.lval = 1'b1;
      raw.data = px[i];
      next_cycle();
    end
    blank(1'b1);  // Line gap while the frame stays open
  endtask

  // Next word against the packed colours
  task automatic expect_pixel(input camera_pkg::pixel_t red, green, blue);
    logic [31:0] expected;
    int          waited;
    expected = {1'b0, green[11:7], blue[11:2], 1'b0, green[6:2], red[11:2]};
    waited   = 0;
    while (word_q.size() == 0)
    begin
      if (waited == 20)
        abort_run($sformatf("Timed out waiting for a pixel word in frame %0d", frame_no));
      else
      begin
        next_cycle();
        waited++;
      end
    end
    compare_values($sformatf("frame %0d words", frame_no), expected, word_q.pop_front());
  endtask

  task automatic expect_count(input logic [`FRAME_COUNT_WIDTH-1:0] count);
    repeat (3) next_cycle();  // Count lands 2 edges after fval low
    compare_values($sformatf("frame %0d digit 0", frame_no), segment_code(count[3:0]), hex[0]);
    for (int d = 1; d < `HEX_DIGITS; d++)
      compare_values($sformatf("frame %0d digit %0d", frame_no, d), segment_code(4'h0), hex[d]);
    compare_values($sformatf("frame %0d extra words", frame_no), 0, word_q.size());
  endtask

  initial
  begin : run_test
    int                             fd;
    int                             code;
    byte                            kind;
    string                          rest;
    camera_pkg::pixel_t             v [4];
    logic [`FRAME_COUNT_WIDTH-1:0]  count;
    rst           = 1'b1;
    raw           = '0;
    capture_start = 1'b0;
    capture_stop  = 1'b0;
    lfsr_state    = 16'd34615;
    frame_no      = 0;
    apply_reset();
    fd = $fopen("camera_pipeline_input.txt", "r");
    if (fd == 0)
      abort_run("Could not open camera_pipeline_input.txt");
    while ($fscanf(fd, " %c", kind) == 1)
    begin
      code = 0;
      case (kind)
        "#": code = $fgets(rest, fd);  // Comment line
        "S": capture_start = 1'b1;
        "T": capture_stop = 1'b1;
        "C":
        begin
          capture_start = 1'b0;
          capture_stop  = 1'b0;
        end
        "R":
        begin
          capture_start = 1'b1;  // Armed before reset so it has a flag to clear
          next_cycle();
          capture_start = 1'b0;
          apply_reset();
        end
        "L":
        begin
          code = $fscanf(fd, " %h %h %h %h", v[0], v[1], v[2], v[3]);
          if (code != 4)
            abort_run("Line record in the input file has too few pixels");
          else
            send_line(v[0], v[1], v[2], v[3]);
        end
        "F":
        begin
          blank(1'b0);  // fval low closes the frame
          frame_no++;
        end
        "E":
        begin
          code = $fscanf(fd, " %h %h %h", v[0], v[1], v[2]);
          if (code != 3)
            abort_run("Expected-colour record in the input file is incomplete");
          else
            expect_pixel(v[0], v[1], v[2]);
        end
        "N":
        begin
          code = $fscanf(fd, " %h", count);
          if (code != 1)
            abort_run("Frame count record in the input file is incomplete");
          else
            expect_count(count);
        end
        default: abort_run($sformatf("Unknown record kind %c in the input file", kind));
      endcase
    end
    $fclose(fd);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== camera_pipeline_input.txt ====
# Kind then hex fields: L pixel0..pixel3, E red green blue, N frame count
# S start high, T stop high, C both low, F frame end, R reset
L 111 222 333 444
L 555 666 777 888
F
N 0
S
L 100 200 300 400
L 500 600 700 800
L 900 a00 b00 c00
F
E 200 380 500
E 200 480 700
E 400 580 700
E a00 780 500
E a00 880 700
E c00 980 700
N 1
C
L fff 0f0 abc 123
T
L 456 789 def 111
L 222 333 444 555
F
E 0f0 bc4 456
E 0f0 922 def
E 123 5e6 def
E 333 4d5 456
E 333 5e6 def
E 555 2aa def
N 2
L 100 200 300 400
L 500 600 700 800
F
N 2
C
R
N 0
L 100 200 300 400
L 500 600 700 800
F
N 0

// ==== camera_pipeline.f ====
+incdir+.
camera_pkg.sv
ccd_capture.sv
line_buffer.sv
bayer_demosaic.sv
frame_count_display.sv
camera_pipeline.sv
camera_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: camera_pipeline

sources:
  - include_dirs:
      - .
    files:
      - camera_pkg.sv
      - ccd_capture.sv
      - line_buffer.sv
      - bayer_demosaic.sv
      - frame_count_display.sv
      - camera_pipeline.sv
      - target: test
        files:
          - camera_pipeline_tb.sv
